/* vlog.f */
+incdir+.
uop_pkg.sv
result_pkg.sv
prf.sv
alu.sv
alu_lane.sv
alu_cluster.sv
tb_clock.sv
alu_cluster_assertions.sv
alu_cluster_tb.sv

/* run.sh */
#!/bin/sh
# build and run the alu_cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module alu_cluster_tb -o alu_cluster_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed"
    exit $status
fi

./obj_dir/alu_cluster_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0

/* alu_cluster_tb.sv */
`include "core_settings.svh"

module alu_cluster_tb
    import uop_pkg::*, result_pkg::*;
();
    typedef struct {
        string              name;
        int                 lane;
        uop_e               op;
        int                 s0, s1;
        bit                 re1;
        int                 dst;
        logic [`WORD_W-1:0] imm, baddr;
    } row_t;

    logic               clk, rst_n;
    logic               issue_valid [2];
    logic               issue_ready [2];
    uop_bundle_t        issue_uop [2];
    logic               finish_valid [2];
    logic [1:0]         finish_ready;
    finish_t            fin [2];
    row_t               tbl [$];
    logic [`WORD_W-1:0] mreg [`PRF_DEPTH]; // reference register file
    finish_t            exp_q [2][$];
    string              name_q [2][$];
    int                 issued [2];
    int                 finished [2];

    tb_clock u_clk (.clk(clk), .rst_n(rst_n));

    alu_cluster uut (
        .clk(clk), .rst_n(rst_n),
        .issue_valid0(issue_valid[0]), .issue_ready0(issue_ready[0]), .issue_uop0(issue_uop[0]),
        .finish_valid0(finish_valid[0]), .finish_ready0(finish_ready[0]), .finish0(fin[0]),
        .issue_valid1(issue_valid[1]), .issue_ready1(issue_ready[1]), .issue_uop1(issue_uop[1]),
        .finish_valid1(finish_valid[1]), .finish_ready1(finish_ready[1]), .finish1(fin[1])
    );

    bind alu_lane alu_cluster_assertions u_chk (.*);

    task automatic stop_run(input string msg);
        $display("CHECK FAILED %s", msg);
        $display("=== FAIL ===");
        $fatal(1, "mismatch against the reference model");
    endtask

    task automatic check_finish(input string name, input finish_t exp, input finish_t act);
        if (exp !== act)
            stop_run($sformatf("%s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [`WORD_W-1:0] exp,
                              input logic [`WORD_W-1:0] act);
        if (exp !== act)
            stop_run($sformatf("%s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_run($sformatf("%s expected %b actual %b", name, exp, act));
    endtask

    task automatic add_row(input string name, input int lane, input uop_e op, input int s0,
                           input int s1, input bit re1, input int dst,
                           input logic [`WORD_W-1:0] imm, input logic [`WORD_W-1:0] baddr);
        tbl.push_back('{name, lane, op, s0, s1, re1, dst, imm, baddr});
    endtask

    function automatic alu_type_e class_of(input uop_e op);
        case (op)
            OR_U, ORI_U, LUI_U, AND_U, ANDI_U, NOR_U, XOR_U, XORI_U: return ALU_LOGIC;
            SLL_U, SLLV_U, SRL_U, SRLV_U, SRA_U, SRAV_U:            return ALU_SHIFT;
            ADD_U, ADDI_U, ADDU_U, SUB_U, SUBU_U,
            SLT_U, SLTI_U, SLTU_U, SLTIU_U:                         return ALU_ARITH;
            MOVE_U:                                                 return ALU_MOVE;
            CLZ_U, CLO_U:                                           return ALU_COUNT;
            default:                                                return ALU_BRANCH;
        endcase
    endfunction

    // leading bits equal to v, counted from the msb
    function automatic logic [`WORD_W-1:0] lead_count(input logic [`WORD_W-1:0] a, input bit v);
        int n;
        n = 0;
        while (n < `WORD_W && a[`WORD_W-1-n] == v)
            n++;
        return n;
    endfunction

    function automatic finish_t model_exec(input row_t e, input logic [`ROB_ID_W-1:0] rob);
        logic [`WORD_W-1:0] a, b, r;
        finish_t            f;
        a = mreg[e.s0];
        b = e.re1 ? mreg[e.s1] : e.imm;
        r = e.imm;
        f = '{rob_id: rob, branch_taken: 1'b0, branch_addr: e.baddr, overflow: 1'b0};
        case (e.op)
            OR_U, ORI_U, LUI_U: r = a | b;
            AND_U:  r = a & b;
            NOR_U:  r = ~(a | b);
            XOR_U:  r = a ^ b;
            SLL_U:  r = b << e.imm[4:0];
            SRA_U:  r = $signed(b) >>> e.imm[4:0];
            SRAV_U: r = $signed(b) >>> a[4:0];
            ADD_U: begin
                r = a + b;
                f.overflow = a[`WORD_W-1] == b[`WORD_W-1] && r[`WORD_W-1] != a[`WORD_W-1];
            end
            SUB_U: begin
                r = a - b;
                f.overflow = a[`WORD_W-1] != b[`WORD_W-1] && r[`WORD_W-1] != a[`WORD_W-1];
            end
            SLT_U:  r = {31'b0, $signed(a) < $signed(b)};
            SLTU_U: r = {31'b0, a < b};
            MOVE_U: r = a;
            CLZ_U:  r = lead_count(a, 1'b0);
            CLO_U:  r = lead_count(a, 1'b1);
            BEQ_U:  f.branch_taken = a == b;
            BNE_U:  f.branch_taken = a != b;
            BGEZ_U: f.branch_taken = !a[`WORD_W-1];
            BGTZ_U: f.branch_taken = !a[`WORD_W-1] && a != 0;
            BLEZ_U: f.branch_taken = a[`WORD_W-1] || a == 0;
            BLTZ_U: f.branch_taken = a[`WORD_W-1];
            J_U:    f.branch_taken = 1'b1;
            JR_U: begin
                f.branch_taken = 1'b1;
                f.branch_addr = a;
            end
            default: r = '0;
        endcase
        if (e.dst != 0)
            mreg[e.dst] = r;
        return f;
    endfunction

    task automatic issue_row(input int idx);
        row_t        e;
        uop_bundle_t u;
        int          o;
        e = tbl[idx];
        o = 1 - e.lane;
        // a producer still parked in the other lane's stage register would be missed
        while (issued[o] - finished[o] > 1)
            @(posedge clk);
        u = '0;
        u.valid = 1'b1;
        u.uop = e.op;
        u.alu_type = class_of(e.op);
        u.op0_paddr = e.s0[`PTAG_W-1:0];
        u.op1_paddr = e.s1[`PTAG_W-1:0];
        u.op0_re = 1'b1;
        u.op1_re = e.re1;
        u.dst_paddr = e.dst[`PTAG_W-1:0];
        u.dst_we = e.dst != 0;
        u.imm = e.imm;
        u.branch_addr = e.baddr;
        u.rob_id = idx[`ROB_ID_W-1:0];
        issue_valid[e.lane] <= 1'b1;
        issue_uop[e.lane] <= u;
        do
            @(negedge clk);
        while (!issue_ready[e.lane]);
        exp_q[e.lane].push_back(model_exec(e, u.rob_id));
        name_q[e.lane].push_back(e.name);
        issued[e.lane]++;
        @(posedge clk);
        issue_valid[e.lane] <= 1'b0;
    endtask

    initial begin
        void'($urandom(1));
        finish_ready = 2'b00;
        forever begin
            @(posedge clk);
            finish_ready <= {$urandom % 4 != 0, $urandom % 4 != 0};
        end
    end

    // handshake is decided before the next rising edge
    always @(negedge clk) begin
        finish_t exp_rec;
        string   rec_name;
        for (int l = 0; l < 2; l++) begin
            if (rst_n && finish_valid[l] && finish_ready[l]) begin
                if (exp_q[l].size() == 0) begin
                    $display("lane %0d returned a finish record with no op outstanding", l);
                    $display("=== FAIL ===");
                    $fatal(1, "unexpected finish record");
                end
                exp_rec = exp_q[l].pop_front();
                rec_name = name_q[l].pop_front();
                check_word($sformatf("%s target", rec_name), exp_rec.branch_addr,
                           fin[l].branch_addr);
                check_finish(rec_name, exp_rec, fin[l]);
                finished[l]++;
            end
        end
    end

    initial begin
        #1;
        repeat (tbl.size() * 20 + 20) @(posedge clk);
        $display("=== FAIL ===");
        $fatal(1, "watchdog timeout, the finish records did not all arrive in time");
    end

    initial begin
        for (int l = 0; l < 2; l++) begin
            issue_valid[l] = 1'b0;
            issue_uop[l] = '0;
            issued[l] = 0;
            finished[l] = 0;
        end
        for (int i = 0; i < `PRF_DEPTH; i++)
            mreg[i] = '0;
        add_row("jr_reset", 0, JR_U, 5, 0, 0, 0, 0, 0);
        add_row("ori_const", 0, ORI_U, 0, 0, 0, 1, 32'h7fff_fff0, 0);
        add_row("lui_const", 1, LUI_U, 0, 0, 0, 2, 32'h8000_0000, 0);
        add_row("ori_small", 0, ORI_U, 0, 0, 0, 3, 32'h0000_00f0, 0);
        add_row("add_ovf", 1, ADD_U, 1, 1, 1, 4, 0, 0);
        add_row("add_fwd", 1, ADD_U, 4, 3, 1, 5, 0, 0);
        add_row("sub_ovf", 0, SUB_U, 2, 3, 1, 6, 0, 0);
        add_row("and", 1, AND_U, 1, 3, 1, 7, 0, 0);
        add_row("nor", 0, NOR_U, 1, 3, 1, 8, 0, 0);
        add_row("xor", 1, XOR_U, 1, 3, 1, 9, 0, 0);
        add_row("slt", 0, SLT_U, 2, 3, 1, 10, 0, 0);
        add_row("sltu", 1, SLTU_U, 2, 3, 1, 11, 0, 0);
        add_row("sll", 0, SLL_U, 0, 3, 1, 12, 4, 0);
        add_row("sra_neg", 1, SRA_U, 0, 2, 1, 13, 8, 0);
        add_row("srav", 0, SRAV_U, 3, 2, 1, 14, 0, 0);
        add_row("clz_zero", 1, CLZ_U, 0, 0, 0, 15, 0, 0);
        add_row("nor_ones", 0, NOR_U, 0, 0, 1, 16, 0, 0);
        add_row("clo_ones", 0, CLO_U, 16, 0, 0, 17, 0, 0);
        add_row("clz_mixed", 1, CLZ_U, 3, 0, 0, 18, 0, 0);
        add_row("clo_mixed", 0, CLO_U, 2, 0, 0, 19, 0, 0);
        add_row("move", 1, MOVE_U, 5, 0, 0, 20, 0, 0);
        add_row("add_xlane", 0, ADD_U, 20, 3, 1, 21, 0, 0); // consumer right behind lane 1
        add_row("sub_min_ovf", 1, SUB_U, 0, 2, 1, 22, 0, 0);
        add_row("beq", 0, BEQ_U, 1, 1, 1, 0, 0, 32'h0000_0400);
        add_row("bne", 1, BNE_U, 1, 3, 1, 0, 0, 32'h0000_0404);
        add_row("bgez_neg", 0, BGEZ_U, 2, 0, 1, 0, 0, 32'h0000_0408);
        add_row("bgtz", 1, BGTZ_U, 3, 0, 1, 0, 0, 32'h0000_040c);
        add_row("blez_zero", 0, BLEZ_U, 0, 0, 1, 0, 0, 32'h0000_0410);
        add_row("bltz", 1, BLTZ_U, 2, 0, 1, 0, 0, 32'h0000_0414);
        add_row("j", 0, J_U, 0, 0, 0, 0, 0, 32'h0040_1000);
        add_row("jr", 1, JR_U, 4, 0, 0, 0, 0, 0);
        for (int t = 1; t <= 22; t++)
            add_row($sformatf("readback_t%0d", t), t % 2, JR_U, t, 0, 0, 0, 0, 0);

        while (rst_n !== 1'b1)
            @(posedge clk);
        @(negedge clk);
        for (int l = 0; l < 2; l++) begin
            check_ready($sformatf("reset issue_ready%0d", l), 1'b1, issue_ready[l]);
            check_ready($sformatf("reset finish_valid%0d", l), 1'b0, finish_valid[l]);
        end
        @(posedge clk);
        for (int i = 0; i < tbl.size(); i++)
            issue_row(i);
        while (issued[0] != finished[0] || issued[1] != finished[1])
            @(posedge clk);
        repeat (2) @(posedge clk);
        @(negedge clk);
        for (int l = 0; l < 2; l++)
            check_ready($sformatf("idle finish_valid%0d", l), 1'b0, finish_valid[l]);
        $display("=== PASS ===");
        $finish;
    end
endmodule

/* alu_cluster_assertions.sv */
module alu_cluster_assertions
    import result_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       issue_ready,
    input logic       finish_valid,
    input logic       finish_ready,
    input finish_t    finish,
    input prf_winfo_t wb
);
    // a stalled record must not move
    finish_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        finish_valid && !finish_ready |=> finish_valid && $stable(finish))
        else $error("finish record changed while stalled");

    reset_state: assert property (@(posedge clk)
        !rst_n |=> !finish_valid && issue_ready && !wb.wen)
        else $error("lane not idle after reset");
endmodule

/* tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end
endmodule

/* alu_cluster.sv */
`include "core_settings.svh"

module alu_cluster
    import uop_pkg::*, result_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // lane 0
    input  logic        issue_valid0,
    output logic        issue_ready0,
    input  uop_bundle_t issue_uop0,
    output logic        finish_valid0,
    input  logic        finish_ready0,
    output finish_t     finish0,
    // lane 1
    input  logic        issue_valid1,
    output logic        issue_ready1,
    input  uop_bundle_t issue_uop1,
    output logic        finish_valid1,
    input  logic        finish_ready1,
    output finish_t     finish1
);
    logic [`PTAG_W-1:0] tag0, tag1, tag2, tag3;
    prf_rdata_t         rdata0, rdata1;
    prf_winfo_t         wb0, wb1;

    prf u_prf (
        .clk         (clk),
        .rst_n       (rst_n),
        .rtag0       (tag0),
        .rtag1       (tag1),
        .rtag2       (tag2),
        .rtag3       (tag3),
        .rdata_lane0 (rdata0),
        .rdata_lane1 (rdata1),
        .wr0         (wb0),
        .wr1         (wb1)
    );

    alu_lane u_lane0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid0),
        .issue_ready  (issue_ready0),
        .issue_uop    (issue_uop0),
        .rtag0        (tag0),
        .rtag1        (tag1),
        .rdata        (rdata0),
        .bypass_other (wb1),
        .wb           (wb0),
        .finish_valid (finish_valid0),
        .finish_ready (finish_ready0),
        .finish       (finish0)
    );

    alu_lane u_lane1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid1),
        .issue_ready  (issue_ready1),
        .issue_uop    (issue_uop1),
        .rtag0        (tag2),
        .rtag1        (tag3),
        .rdata        (rdata1),
        .bypass_other (wb0),
        .wb           (wb1),
        .finish_valid (finish_valid1),
        .finish_ready (finish_ready1),
        .finish       (finish1)
    );

endmodule

/* alu_lane.sv */
`include "core_settings.svh"

module alu_lane
    import uop_pkg::*, result_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    output logic               issue_ready,
    input  uop_bundle_t        issue_uop,
    output logic [`PTAG_W-1:0] rtag0,
    output logic [`PTAG_W-1:0] rtag1,
    input  prf_rdata_t         rdata,
    input  prf_winfo_t         bypass_other,
    output prf_winfo_t         wb,
    output logic               finish_valid,
    input  logic               finish_ready,
    output finish_t            finish
);
    logic        stage_valid, stage_hold;
    uop_bundle_t stage_uop, alu_uop;
    prf_rdata_t  stage_rdata;
    logic        res_valid, res_fresh, res_free, res_load;
    prf_winfo_t  res_wb, alu_wb;
    finish_t     res_finish, alu_finish;

    assign res_free = !res_valid || finish_ready;
    assign res_load = stage_valid && res_free;
    assign stage_hold = stage_valid && !res_free;
    assign issue_ready = !stage_hold;

    // a held op re-reads its sources so a drained bypass is not lost
    assign rtag0 = stage_hold ? stage_uop.op0_paddr : issue_uop.op0_paddr;
    assign rtag1 = stage_hold ? stage_uop.op1_paddr : issue_uop.op1_paddr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            res_valid <= 1'b0;
            res_fresh <= 1'b0;
        end else begin
            if (issue_ready)
                stage_valid <= issue_valid;
            if (res_free)
                res_valid <= stage_valid;
            res_fresh <= res_load; // write the prf once per result
        end
    end

    always_ff @(posedge clk) begin
        if (issue_ready)
            stage_uop <= issue_uop;
        stage_rdata <= rdata;
        if (res_load) begin
            res_wb <= alu_wb;
            res_finish <= alu_finish;
        end
    end

    always_comb begin
        alu_uop = stage_uop;
        alu_uop.valid = stage_valid;
        wb = res_wb;
        wb.wen = res_wb.wen && res_fresh;
    end

    alu u_alu (
        .uop          (alu_uop),
        .rdata        (stage_rdata),
        .bypass_own   (wb),
        .bypass_other (bypass_other),
        .wb           (alu_wb),
        .finish       (alu_finish)
    );

    assign finish_valid = res_valid;
    assign finish = res_finish;

endmodule

/* alu.sv */
`include "core_settings.svh"

module alu
    import uop_pkg::*, result_pkg::*;
(
    input  uop_bundle_t uop,
    input  prf_rdata_t  rdata,
    input  prf_winfo_t  bypass_own,
    input  prf_winfo_t  bypass_other,
    output prf_winfo_t  wb,
    output finish_t     finish
);
    localparam int MSB = `WORD_W - 1;

    uop_e               op;
    logic [`WORD_W-1:0] src0, src1;
    logic [`WORD_W-1:0] logic_res, shift_res, arith_res, count_res, result;
    logic [`WORD_W-1:0] src1_neg, sum, target;
    logic [4:0]         shamt;
    logic               sub_op, slt_op, lt, taken, is_branch, overflow;

    // own lane wins over the other lane
    function automatic logic [`WORD_W-1:0] pick_src(
        input logic [`PTAG_W-1:0] tag,
        input logic [`WORD_W-1:0] prf_val,
        input prf_winfo_t         own,
        input prf_winfo_t         other
    );
        if (own.wen && own.rd == tag)
            return own.wdata;
        if (other.wen && other.rd == tag)
            return other.wdata;
        return prf_val;
    endfunction

    function automatic logic [`WORD_W-1:0] lead_zeros(input logic [`WORD_W-1:0] v);
        logic [`WORD_W-1:0] n;
        logic               seen;
        n = '0;
        seen = 1'b0;
        for (int i = MSB; i >= 0; i--) begin
            seen = seen | v[i];
            if (!seen)
                n = n + 1'b1;
        end
        return n;
    endfunction

    assign op = uop.uop;
    assign src0 = uop.op0_re ? pick_src(uop.op0_paddr, rdata.rs0_data, bypass_own, bypass_other)
                             : '0;
    assign src1 = uop.op1_re ? pick_src(uop.op1_paddr, rdata.rs1_data, bypass_own, bypass_other)
                             : uop.imm;

    always_comb begin
        case (op)
            OR_U, ORI_U, LUI_U: logic_res = src0 | src1; // lui imm arrives pre-shifted
            AND_U, ANDI_U:      logic_res = src0 & src1;
            NOR_U:              logic_res = ~(src0 | src1);
            XOR_U, XORI_U:      logic_res = src0 ^ src1;
            default:            logic_res = '0;
        endcase
    end

    // value is always source 1
    assign shamt = (op == SLL_U || op == SRL_U || op == SRA_U) ? uop.imm[4:0] : src0[4:0];

    always_comb begin
        case (op)
            SLL_U, SLLV_U: shift_res = src1 << shamt;
            SRL_U, SRLV_U: shift_res = src1 >> shamt;
            SRA_U, SRAV_U: shift_res = $signed(src1) >>> shamt;
            default:       shift_res = '0;
        endcase
    end

    assign sub_op = op == SUB_U || op == SUBU_U || op == SLT_U || op == SLTI_U;
    assign slt_op = op == SLT_U || op == SLTI_U || op == SLTU_U || op == SLTIU_U;
    assign src1_neg = sub_op ? ~src1 + 1'b1 : src1;
    assign sum = src0 + src1_neg;
    assign lt = (op == SLT_U || op == SLTI_U) ? $signed(src0) < $signed(src1) : src0 < src1;
    assign arith_res = slt_op ? {{MSB{1'b0}}, lt} : sum;

    // result sign flips against source 0
    assign overflow = (((op == ADD_U || op == ADDI_U) && src0[MSB] == src1[MSB]) ||
                       (op == SUB_U && src0[MSB] != src1[MSB])) &&
                      sum[MSB] != src0[MSB];

    assign count_res = (op == CLZ_U) ? lead_zeros(src0) : lead_zeros(~src0);

    always_comb begin
        case (op)
            BEQ_U:                    taken = src0 == src1;
            BNE_U:                    taken = src0 != src1;
            BGEZ_U:                   taken = !src0[MSB];
            BGTZ_U:                   taken = !src0[MSB] && src0 != '0;
            BLEZ_U:                   taken = src0[MSB] || src0 == '0;
            BLTZ_U:                   taken = src0[MSB];
            J_U, JAL_U, JR_U, JALR_U: taken = 1'b1;
            default:                  taken = 1'b0;
        endcase
    end

    assign target = (op == JR_U || op == JALR_U) ? src0 : uop.branch_addr;
    assign is_branch = uop.alu_type == ALU_BRANCH;

    always_comb begin
        case (uop.alu_type)
            ALU_LOGIC:  result = logic_res;
            ALU_SHIFT:  result = shift_res;
            ALU_ARITH:  result = arith_res;
            ALU_MOVE:   result = src0;
            ALU_COUNT:  result = count_res;
            ALU_BRANCH: result = uop.imm; // link address from decode
            default:    result = '0;
        endcase
    end

    assign wb.wen = uop.valid && uop.dst_we;
    assign wb.rd = uop.dst_paddr;
    assign wb.wdata = result;

    // non-branch ops carry the issue fields through
    assign finish.rob_id = uop.rob_id;
    assign finish.branch_taken = is_branch ? taken : uop.branch_taken;
    assign finish.branch_addr = is_branch ? target : uop.branch_addr;
    assign finish.overflow = overflow;

endmodule

/* prf.sv */
`include "core_settings.svh"

module prf
    import result_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`PTAG_W-1:0] rtag0,
    input  logic [`PTAG_W-1:0] rtag1,
    input  logic [`PTAG_W-1:0] rtag2,
    input  logic [`PTAG_W-1:0] rtag3,
    output prf_rdata_t         rdata_lane0,
    output prf_rdata_t         rdata_lane1,
    input  prf_winfo_t         wr0,
    input  prf_winfo_t         wr1
);
    logic [`WORD_W-1:0] regs [`PRF_DEPTH];

    // a write in flight is visible to readers in the same cycle
    function automatic logic [`WORD_W-1:0] read_word(input logic [`PTAG_W-1:0] tag);
        if (wr0.wen && wr0.rd == tag)
            return wr0.wdata;
        if (wr1.wen && wr1.rd == tag)
            return wr1.wdata;
        return regs[tag];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PRF_DEPTH; i++)
                regs[i] <= '0;
        end else begin
            if (wr0.wen)
                regs[wr0.rd] <= wr0.wdata;
            if (wr1.wen)
                regs[wr1.rd] <= wr1.wdata; // never the same tag as wr0
        end
    end

    always_comb begin
        rdata_lane0.rs0_data = read_word(rtag0);
        rdata_lane0.rs1_data = read_word(rtag1);
        rdata_lane1.rs0_data = read_word(rtag2);
        rdata_lane1.rs1_data = read_word(rtag3);
    end

endmodule

/* result_pkg.sv */
`include "core_settings.svh"

package result_pkg;

    // both source operands of one lane
    typedef struct packed {
        logic [`WORD_W-1:0] rs0_data;
        logic [`WORD_W-1:0] rs1_data;
    } prf_rdata_t;

    // prf write, also used as bypass
    typedef struct packed {
        logic               wen;
        logic [`PTAG_W-1:0] rd;
        logic [`WORD_W-1:0] wdata;
    } prf_winfo_t;

    typedef struct packed {
        logic [`ROB_ID_W-1:0] rob_id;
        logic                 branch_taken;
        logic [`WORD_W-1:0]   branch_addr;
        logic                 overflow;
    } finish_t;

endpackage

/* uop_pkg.sv */
`include "core_settings.svh"

package uop_pkg;

    typedef enum logic [5:0] {
        NOP_U,
        // logic
        OR_U,
        ORI_U,
        LUI_U,
        AND_U,
        ANDI_U,
        NOR_U,
        XOR_U,
        XORI_U,
        // shifts, immediate forms take shamt from imm
        SLL_U, SLLV_U,
        SRL_U, SRLV_U,
        SRA_U, SRAV_U,
        // arithmetic and compare
        ADD_U, ADDI_U, ADDU_U,
        SUB_U, SUBU_U,
        SLT_U, SLTI_U, SLTU_U, SLTIU_U,
        MOVE_U,
        CLZ_U,
        CLO_U,
        // branches and jumps
        BEQ_U, BNE_U,
        BGEZ_U, BGTZ_U, BLEZ_U, BLTZ_U,
        J_U, JAL_U, JR_U, JALR_U
    } uop_e;

    typedef enum logic [2:0] {
        ALU_LOGIC, ALU_SHIFT, ALU_ARITH,
        ALU_MOVE, ALU_COUNT, ALU_BRANCH
    } alu_type_e;

    typedef struct packed {
        logic                 valid;
        uop_e                 uop;
        alu_type_e            alu_type;
        logic [`PTAG_W-1:0]   op0_paddr;
        logic [`PTAG_W-1:0]   op1_paddr;
        logic                 op0_re;
        logic                 op1_re;     // clear selects imm as source 1
        logic [`PTAG_W-1:0]   dst_paddr;
        logic                 dst_we;
        logic [`WORD_W-1:0]   imm;
        logic [`WORD_W-1:0]   branch_addr;
        logic                 branch_taken;
        logic [`ROB_ID_W-1:0] rob_id;
    } uop_bundle_t;

endpackage

/* core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath width
`define WORD_W 32

// physical register file
`define PRF_DEPTH 64
`define PTAG_W 6

`define ROB_ID_W 5 // matches a 32-entry ROB

`endif
